// File: design/spi_pkg.sv
package spi_pkg;

	//////////////////////////////////////////////////
	// Data and mode types
	//////////////////////////////////////////////////

	typedef logic [7:0] spi_byte_t;

	// SCLK half period is div + 1 clk cycles
	typedef logic [7:0] spi_div_t;

	typedef struct packed {
		logic     cpol;
		logic     cpha;
		spi_div_t div;
	} spi_cfg_t;

	// Request from decoder to shift engine
	typedef struct packed {
		spi_cfg_t  cfg;
		spi_byte_t tx;
	} spi_xfer_t;

	// First and second SCLK edge of a bit period
	typedef struct packed {
		logic lead;
		logic trail;
	} spi_edge_t;

	//////////////////////////////////////////////////
	// Host command word, two views
	//////////////////////////////////////////////////

	typedef struct packed {
		logic       kind;
		logic [4:0] rsvd;
		logic       cpol;
		logic       cpha;
		spi_div_t   div;
	} spi_cfg_word_t;

	typedef struct packed {
		logic       kind;
		logic [6:0] rsvd;
		spi_byte_t  payload;
	} spi_data_word_t;

	typedef union packed {
		spi_cfg_word_t  cfg;
		spi_data_word_t data;
	} spi_host_word_u;

	localparam logic SPI_KIND_CFG  = 1'b1;
	localparam logic SPI_KIND_DATA = 1'b0;

	localparam int SPI_BITS  = 8;
	localparam int SPI_CNT_W = $clog2(SPI_BITS + 1);

	// Mode 0, SCLK at clk/4
	localparam spi_cfg_t SPI_CFG_RESET = '{cpol: 1'b0, cpha: 1'b0, div: 8'd1};

	// Engine states, gray coded
	localparam logic [1:0] SPI_ST_IDLE  = 2'b00;
	localparam logic [1:0] SPI_ST_LOAD  = 2'b01;
	localparam logic [1:0] SPI_ST_SHIFT = 2'b11;
	localparam logic [1:0] SPI_ST_DONE  = 2'b10;

endpackage

// File: design/spi_cmd_decode.sv
`timescale 1ns/100ps

module spi_cmd_decode (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   host_valid,
	input  spi_pkg::spi_host_word_u host_word,
	input  logic                   busy,
	output logic                   xfer_req,
	output spi_pkg::spi_xfer_t     xfer,
	output logic                   cmd_overrun
);

	import spi_pkg::*;

	spi_cfg_t  cfg_q;
	spi_byte_t tx_q;
	logic      is_cfg;
	logic      is_data;
	logic      drop;

	// Kind bit sits at the top of both views
	assign is_cfg  = host_valid && (host_word.cfg.kind == SPI_KIND_CFG);
	assign is_data = host_valid && (host_word.data.kind == SPI_KIND_DATA);

	// No queue, so a data word is lost while a transfer is running or pending
	assign drop = is_data && (busy || xfer_req);

	//////////////////////////////////////////////////
	// Mode register and request strobes
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cfg_q       <= SPI_CFG_RESET;
			xfer_req    <= 1'b0;
			cmd_overrun <= 1'b0;
		end else begin
			if (is_cfg) begin
				cfg_q.cpol <= host_word.cfg.cpol;
				cfg_q.cpha <= host_word.cfg.cpha;
				cfg_q.div  <= host_word.cfg.div;
			end
			xfer_req    <= is_data && !drop;
			cmd_overrun <= drop;
		end
	end

	// Payload byte of the accepted data word
	always_ff @(posedge clk) begin
		if (is_data && !drop) begin
			tx_q <= host_word.data.payload;
		end
	end

	// The mode field follows the live register. With xfer_req it holds the
	// mode as of the cycle after the data word, and the engine latches it
	// there, so later mode changes never reach a running transfer.
	// Between transfers the engine uses it to park SCLK at the new polarity.
	assign xfer = '{cfg: cfg_q, tx: tx_q};

endmodule

// File: design/spi_sclk_gen.sv
`timescale 1ns/100ps

module spi_sclk_gen (
	input  logic               clk,
	input  logic               rst,
	input  logic               sclk_run,
	input  spi_pkg::spi_cfg_t  cfg,
	output logic               sclk,
	output spi_pkg::spi_edge_t sclk_edge
);

	import spi_pkg::*;

	spi_div_t  half_cnt;
	logic      sclk_q;
	spi_edge_t edge_q;
	logic      toggle;
	logic      at_idle;

	// End of a half period
	assign toggle = sclk_run && (half_cnt == cfg.div);

	// Leaving the idle level is the first edge of a bit
	assign at_idle = (sclk_q == cfg.cpol);

	//////////////////////////////////////////////////
	// Half period counter
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			half_cnt <= '0;
		end else if (!sclk_run || toggle) begin
			half_cnt <= '0;
		end else begin
			half_cnt <= half_cnt + spi_div_t'(1);
		end
	end

	//////////////////////////////////////////////////
	// SCLK and edge marks
	//////////////////////////////////////////////////

	// Parked at cpol while stopped
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sclk_q <= SPI_CFG_RESET.cpol;
		end else if (!sclk_run) begin
			sclk_q <= cfg.cpol;
		end else if (toggle) begin
			sclk_q <= ~sclk_q;
		end
	end

	// Registered together with sclk_q, so a mark is high in the
	// same cycle that SCLK shows its new level
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			edge_q <= '0;
		end else begin
			edge_q.lead  <= toggle && at_idle;
			edge_q.trail <= toggle && !at_idle;
		end
	end

	assign sclk      = sclk_q;
	assign sclk_edge = edge_q;

endmodule

// File: design/spi_shift_engine.sv
`timescale 1ns/100ps

module spi_shift_engine (
	input  logic               clk,
	input  logic               rst,
	input  logic               xfer_req,
	input  spi_pkg::spi_xfer_t xfer,
	input  spi_pkg::spi_edge_t sclk_edge,
	input  logic               miso,
	output logic               busy,
	output logic               sclk_run,
	output spi_pkg::spi_cfg_t  cfg,
	output logic               ss_n,
	output logic               mosi,
	output logic               rx_valid,
	output spi_pkg::spi_byte_t rx_data
);

	import spi_pkg::*;

	logic [1:0]           state;
	logic [1:0]           state_nxt;
	spi_cfg_t             mode_q;
	spi_byte_t            tx_sr;
	spi_byte_t            rx_sr;
	logic [SPI_CNT_W-1:0] samp_cnt;
	logic [SPI_CNT_W-1:0] samp_cnt_nxt;
	logic                 shifting;
	logic                 shift_en;
	logic                 sample_en;
	logic                 finish;

	assign shifting = (state == SPI_ST_SHIFT);

	// cpha 0 samples on the first edge, cpha 1 on the second
	assign shift_en  = shifting && (mode_q.cpha ? sclk_edge.lead : sclk_edge.trail);
	assign sample_en = shifting && (mode_q.cpha ? sclk_edge.trail : sclk_edge.lead);

	assign samp_cnt_nxt = samp_cnt + SPI_CNT_W'(sample_en);

	// Last trailing edge with all bits in
	assign finish = shifting && sclk_edge.trail &&
		(samp_cnt_nxt == SPI_CNT_W'(SPI_BITS));

	//////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////

	always_comb begin
		case (state)
			SPI_ST_IDLE:  state_nxt = xfer_req ? SPI_ST_LOAD : SPI_ST_IDLE;
			SPI_ST_LOAD:  state_nxt = SPI_ST_SHIFT;
			SPI_ST_SHIFT: state_nxt = finish ? SPI_ST_DONE : SPI_ST_SHIFT;
			default:      state_nxt = SPI_ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state    <= SPI_ST_IDLE;
			ss_n     <= 1'b1;
			mosi     <= 1'b0;
			rx_valid <= 1'b0;
			samp_cnt <= '0;
		end else begin
			state    <= state_nxt;
			rx_valid <= (state_nxt == SPI_ST_DONE);
			if (state == SPI_ST_IDLE && xfer_req) begin
				ss_n     <= 1'b0;
				mosi     <= xfer.tx[SPI_BITS-1];
				samp_cnt <= '0;
			end else if (finish) begin
				ss_n     <= 1'b1;
				mosi     <= 1'b0;
				samp_cnt <= samp_cnt_nxt;
			end else if (shifting) begin
				if (shift_en) begin
					mosi <= tx_sr[SPI_BITS-1];
				end
				samp_cnt <= samp_cnt_nxt;
			end
		end
	end

	//////////////////////////////////////////////////
	// Data path
	//////////////////////////////////////////////////

	// With cpha 0 bit 7 is already on mosi, so the register starts at bit 6
	always_ff @(posedge clk) begin
		if (state == SPI_ST_IDLE && xfer_req) begin
			mode_q <= xfer.cfg;
			tx_sr  <= xfer.cfg.cpha ? xfer.tx : {xfer.tx[SPI_BITS-2:0], 1'b0};
		end else if (shift_en) begin
			tx_sr <= {tx_sr[SPI_BITS-2:0], 1'b0};
		end
		if (sample_en) begin
			rx_sr <= {rx_sr[SPI_BITS-2:0], miso};
		end
	end

	// Clock stops at the final edge, even with a one-cycle half period
	assign sclk_run = (state == SPI_ST_LOAD) || (shifting && !finish);

	// Latched mode while busy, otherwise the decoder's live mode
	assign cfg     = (state == SPI_ST_IDLE) ? xfer.cfg : mode_q;
	assign busy    = (state != SPI_ST_IDLE);
	assign rx_data = rx_sr;

endmodule

// File: design/spi_master_top.sv
`timescale 1ns/100ps

module spi_master_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    host_valid,
	input  spi_pkg::spi_host_word_u host_word,
	input  logic                    miso,
	output logic                    sclk,
	output logic                    ss_n,
	output logic                    mosi,
	output logic                    rx_valid,
	output spi_pkg::spi_byte_t      rx_data,
	output logic                    cmd_overrun
);

	import spi_pkg::*;

	logic      xfer_req;
	spi_xfer_t xfer;
	logic      busy;
	logic      sclk_run;
	spi_cfg_t  cfg;
	spi_edge_t sclk_edge;

	//////////////////////////////////////////////////
	// Decoder, engine and clock generator
	//////////////////////////////////////////////////

	spi_cmd_decode decode_i (
		.clk, .rst,
		.host_valid, .host_word,
		.busy, .xfer_req, .xfer,
		.cmd_overrun
	);

	spi_shift_engine engine_i (
		.clk, .rst,
		.xfer_req, .xfer, .sclk_edge, .miso,
		.busy, .sclk_run, .cfg,
		.ss_n, .mosi, .rx_valid, .rx_data
	);

	spi_sclk_gen sclk_gen_i (
		.clk, .rst,
		.sclk_run, .cfg,
		.sclk, .sclk_edge
	);

endmodule

// File: sim/spi_slave_model.sv
`timescale 1ns/100ps

module spi_slave_model (
	input  logic               sclk,
	input  logic               ss_n,
	input  logic               mosi,
	input  logic               cpol,
	input  logic               cpha,
	input  spi_pkg::spi_byte_t reply,
	output logic               miso,
	output spi_pkg::spi_byte_t captured
);

	import spi_pkg::*;

	spi_byte_t out_sr;
	logic      lead;

	initial begin
		miso     = 1'b0;
		captured = '0;
		out_sr   = '0;
		forever begin
			@(negedge ss_n);
			out_sr   = reply;
			captured = '0;
			// cpha 0 puts bit 7 out before the first edge
			if (!cpha) begin
				miso   = out_sr[SPI_BITS-1];
				out_sr = {out_sr[SPI_BITS-2:0], 1'b0};
			end
			while (!ss_n) begin
				@(sclk or ss_n);
				if (!ss_n) begin
					lead = (sclk != cpol);
					// Sample on lead for cpha 0, on trail for cpha 1
					if (lead != cpha) begin
						captured = {captured[SPI_BITS-2:0], mosi};
					end else begin
						miso   = out_sr[SPI_BITS-1];
						out_sr = {out_sr[SPI_BITS-2:0], 1'b0};
					end
				end
			end
		end
	end

endmodule

// File: sim/spi_master_tb.sv
`timescale 1ns/100ps

module spi_master_tb;

	import spi_pkg::*;

	// One line of the vector file
	typedef struct packed {
		logic           send_cfg;
		spi_cfg_t       mode;
		spi_byte_t      tx;
		spi_byte_t      reply;
		logic           inject;
		spi_host_word_u inj_word;
		logic           overrun;
	} vec_t;

	localparam int RAND_TESTS = 4;

	logic           clk;
	logic           rst;
	logic           host_valid;
	spi_host_word_u host_word;
	logic           miso;
	logic           sclk;
	logic           ss_n;
	logic           mosi;
	logic           rx_valid;
	spi_byte_t      rx_data;
	logic           cmd_overrun;
	logic           slave_cpol;
	logic           slave_cpha;
	spi_byte_t      slave_reply;
	spi_byte_t      slave_rx;
	vec_t           vecs[$];
	string          names[$];
	logic [31:0]    lfsr = 32'h51f2_0ead;
	int             n_tests;
	int             byte_errs;
	int             flag_errs;
	int             count_errs;
	int             other_errs;

	always #10 clk = ~clk;

	spi_master_top dut_i (
		.clk, .rst, .host_valid, .host_word, .miso,
		.sclk, .ss_n, .mosi, .rx_valid, .rx_data, .cmd_overrun
	);

	spi_slave_model slave_i (
		.sclk, .ss_n, .mosi, .cpol(slave_cpol), .cpha(slave_cpha),
		.reply(slave_reply), .miso, .captured(slave_rx)
	);

	//////////////////////////////////////////////////
	// Compare tasks and random bytes
	//////////////////////////////////////////////////

	task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t act);
		if (act !== exp) begin
			byte_errs++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			flag_errs++;
			$display("** Error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			count_errs++;
			$display("** Error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_byte(output spi_byte_t b);
		b = '0;
		for (int i = 0; i < SPI_BITS; i++) begin
			lfsr = lfsr_step(lfsr);
			b    = {b[SPI_BITS-2:0], lfsr[0]};
		end
	endtask

	//////////////////////////////////////////////////
	// Host side stimulus
	//////////////////////////////////////////////////

	task automatic send_cfg(input spi_cfg_t mode);
		spi_host_word_u w;
		w.cfg.kind = SPI_KIND_CFG;
		w.cfg.rsvd = '0;
		w.cfg.cpol = mode.cpol;
		w.cfg.cpha = mode.cpha;
		w.cfg.div  = mode.div;
		@(posedge clk);
		host_valid <= 1'b1;
		host_word  <= w;
		@(posedge clk);
		host_valid <= 1'b0;
	endtask

	// SCLK parks two cycles after the register update
	task automatic check_idle(input string name, input logic cpol);
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_flag({name, "/idle_ss_n"}, 1'b1, ss_n);
		check_flag({name, "/idle_sclk"}, cpol, sclk);
	endtask

	task automatic run_transfer(input string name, input spi_cfg_t mode, input spi_byte_t tx,
		input spi_byte_t reply, input logic inject, input spi_host_word_u inj_word,
		input logic ovr_exp);
		spi_host_word_u w;
		int             cycles;
		int             ovr_cnt;
		w.data.kind    = SPI_KIND_DATA;
		w.data.rsvd    = '0;
		w.data.payload = tx;
		cycles  = 0;
		ovr_cnt = 0;
		@(posedge clk);
		host_valid  <= 1'b1;
		host_word   <= w;
		slave_cpol  <= mode.cpol;
		slave_cpha  <= mode.cpha;
		slave_reply <= reply;
		do begin
			@(posedge clk);
			cycles++;
			// Extra word lands while the engine is busy
			host_valid <= inject && (cycles == 4);
			host_word  <= inj_word;
			@(negedge clk);
			if (cmd_overrun) ovr_cnt++;
		end while (!rx_valid);
		check_byte({name, "/rx_data"}, reply, rx_data);
		check_byte({name, "/slave_rx"}, tx, slave_rx);
		check_count({name, "/latency"}, 2 + 16 * (int'(mode.div) + 1) + 1, cycles);
		check_flag({name, "/overrun"}, ovr_exp, ovr_cnt != 0);
		check_flag({name, "/overrun_once"}, 1'b1, ovr_cnt <= 1);
	endtask

	task automatic load_vectors();
		int    fd;
		int    n;
		int    c[9];
		string line;
		string nm;
		vec_t  v;
		fd = $fopen("sim/spi_vectors.txt", "r");
		if (fd == 0) begin
			other_errs++;
			$display("Cannot open the vector file sim/spi_vectors.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", nm,
						c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8]);
					if (n == 10) begin
						v.send_cfg  = c[0][0];
						v.mode.cpol = c[1][0];
						v.mode.cpha = c[2][0];
						v.mode.div  = c[3][7:0];
						v.tx        = c[4][7:0];
						v.reply     = c[5][7:0];
						v.inject    = c[6][0];
						v.inj_word  = c[7][15:0];
						v.overrun   = c[8][0];
						vecs.push_back(v);
						names.push_back(nm);
					end
				end
			end
			$fclose(fd);
			if (vecs.size() == 0) begin
				other_errs++;
				$display("The vector file holds no test lines");
			end
		end
		n_tests = vecs.size() + RAND_TESTS;
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		spi_cfg_t  mode;
		spi_byte_t tx;
		spi_byte_t rep;
		clk         = 1'b0;
		rst         = 1'b1;
		host_valid  = 1'b0;
		host_word   = '0;
		slave_cpol  = 1'b0;
		slave_cpha  = 1'b0;
		slave_reply = '0;
		mode        = SPI_CFG_RESET;
		load_vectors();
		@(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_flag("reset/ss_n", 1'b1, ss_n);
			check_flag("reset/sclk", 1'b0, sclk);
			check_flag("reset/mosi", 1'b0, mosi);
			check_flag("reset/rx_valid", 1'b0, rx_valid);
			check_flag("reset/cmd_overrun", 1'b0, cmd_overrun);
		end
		foreach (vecs[i]) begin
			mode = vecs[i].mode;
			if (vecs[i].send_cfg) send_cfg(mode);
			check_idle(names[i], mode.cpol);
			run_transfer(names[i], mode, vecs[i].tx, vecs[i].reply,
				vecs[i].inject, vecs[i].inj_word, vecs[i].overrun);
		end
		// Random bytes in the last mode
		for (int k = 0; k < RAND_TESTS; k++) begin
			rand_byte(tx);
			rand_byte(rep);
			run_transfer("lfsr", mode, tx, rep, 1'b0, '0, 1'b0);
		end
		$display("Errors: %0d byte, %0d flag, %0d count, %0d other",
			byte_errs, flag_errs, count_errs, other_errs);
		if (byte_errs + flag_errs + count_errs + other_errs == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Longest transfer is 16 x 256 cycles plus setup
	initial begin
		wait (n_tests > 0);
		#(longint'(n_tests) * (16 * 257 + 20) * 20);
		$display("Timeout: the tests did not finish in the allowed time");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: sim/spi_vectors.txt
# Columns: name send_cfg cpol cpha div tx reply inject inject_word overrun (all hex but name)
# inject sends inject_word four cycles into the transfer, overrun is the expected pulse
mode0      1 0 0 01 a5 3c 0 0000 0
mode1      1 0 1 01 5a c3 0 0000 0
mode2      1 1 0 01 f0 0f 0 0000 0
mode3      1 1 1 01 81 7e 0 0000 0
div2       1 0 0 02 96 69 0 0000 0
div5       1 1 1 05 c4 2d 0 0000 0
div_10     1 0 1 10 0e e1 0 0000 0
div_max    1 1 0 ff 12 ed 0 0000 0
overrun    1 1 0 04 3b b3 1 0055 1
cfg_mid    1 0 0 03 d2 2d 1 8305 0
after_cfg  0 1 1 05 6c 93 0 0000 0
mode_back  1 0 0 02 00 ff 0 0000 0

// File: filelist.f
design/spi_pkg.sv
design/spi_cmd_decode.sv
design/spi_sclk_gen.sv
design/spi_shift_engine.sv
design/spi_master_top.sv
sim/spi_slave_model.sv
sim/spi_master_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module spi_master_tb -f filelist.f -o spi_master_sim
./obj_dir/spi_master_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
